//--- dram_cache_pkg.sv
`default_nettype none

package dram_cache_pkg;
	localparam int ADDR_WIDTH     = 32;
	localparam int OFFSET_WIDTH   = 6;	// 64-byte lines.
	localparam int INDEX_WIDTH    = 6;	// 64 sets.
	localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
	localparam int TID_WIDTH      = 8;
	localparam int FIFO_DEPTH     = 4;
	localparam int FIFO_AFULL     = 3;
	localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
	localparam int NUM_SETS       = 1 << INDEX_WIDTH;
	localparam int TAG_LSB        = OFFSET_WIDTH + INDEX_WIDTH;
	localparam int ENTRY_WIDTH    = 1 + TID_WIDTH + ADDR_WIDTH;

	typedef logic [ADDR_WIDTH-1:0]     addr_t;
	typedef logic [INDEX_WIDTH-1:0]    index_t;
	typedef logic [TAG_WIDTH-1:0]      tag_t;
	typedef logic [TID_WIDTH-1:0]      tid_t;
	typedef logic [ENTRY_WIDTH-1:0]    fifo_entry_t;	// {write, tid, addr}.
	typedef logic [FIFO_PTR_WIDTH-1:0] fifo_ptr_t;
	typedef logic [FIFO_CNT_WIDTH-1:0] fifo_cnt_t;

	typedef enum logic {S_IDLE, S_REQ} extr_state_t;

	function automatic index_t addr_index(input addr_t addr);
		return addr[TAG_LSB-1:OFFSET_WIDTH];
	endfunction

	function automatic tag_t addr_tag(input addr_t addr);
		return addr[ADDR_WIDTH-1:TAG_LSB];
	endfunction

	function automatic fifo_entry_t make_entry(input logic write, input tid_t tid, input addr_t addr);
		return {write, tid, addr};
	endfunction
endpackage

`default_nettype wire

//--- index_extractor.sv
`timescale 1ns/10ps
`default_nettype none

module index_extractor import dram_cache_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,

	input  wire addr_t  ar_addr_i,
	input  wire         ar_valid_i,
	output logic        ar_ready_o,

	input  wire addr_t  aw_addr_i,
	input  wire         aw_valid_i,
	output logic        aw_ready_o,

	output addr_t       tag_ar_addr_o,
	output logic        tag_ar_valid_o,
	input  wire         tag_ar_ready_i,

	input  wire         fifo_afull_i,
	output logic        fifo_wren_o,
	output fifo_entry_t fifo_wdata_o
);

	extr_state_t state, state_n;
	tid_t        tid, tid_n;
	logic        last_rd, last_rd_n;	// 1 when the last grant went to the read channel.
	logic        req_valid, req_valid_n;
	logic        wren, wren_n;
	addr_t       index_addr;
	fifo_entry_t wdata;
	logic        can_accept;
	logic        grant_rd, grant_wr;
	addr_t       sel_addr;

	assign can_accept = (state == S_IDLE) && !fifo_afull_i;
	// a waiting write wins after a read, and a waiting read wins after a write.
	assign grant_rd   = can_accept && ar_valid_i && (!aw_valid_i || !last_rd);
	assign grant_wr   = can_accept && aw_valid_i && !grant_rd;
	assign sel_addr   = grant_rd ? ar_addr_i : aw_addr_i;

	always_comb begin
		state_n     = state;
		tid_n       = tid;
		last_rd_n   = last_rd;
		req_valid_n = req_valid;
		wren_n      = 1'b0;	// push is a single-cycle pulse.

		case (state)
			S_IDLE: begin
				if (grant_rd || grant_wr) begin
					state_n     = S_REQ;
					req_valid_n = 1'b1;
					wren_n      = 1'b1;
					last_rd_n   = grant_rd;
					if (grant_rd)
						tid_n = tid + 1'b1;	// wraps at TID_WIDTH.
				end
			end
			S_REQ: begin
				if (tag_ar_ready_i) begin
					state_n     = S_IDLE;
					req_valid_n = 1'b0;
				end
			end
			default: state_n = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			tid       <= tid_t'(1);
			last_rd   <= 1'b0;
			req_valid <= 1'b0;
			wren      <= 1'b0;
		end else begin
			state     <= state_n;
			tid       <= tid_n;
			last_rd   <= last_rd_n;
			req_valid <= req_valid_n;
			wren      <= wren_n;
		end
	end

	always_ff @(posedge clk) begin
		if (grant_rd || grant_wr) begin
			// line-aligned index, tag and offset bits zeroed.
			index_addr <= addr_t'({addr_index(sel_addr), {OFFSET_WIDTH{1'b0}}});
			wdata      <= make_entry(grant_wr, grant_rd ? tid : tid_t'(0), sel_addr);
		end
	end

	assign ar_ready_o     = grant_rd;
	assign aw_ready_o     = grant_wr;
	assign tag_ar_addr_o  = index_addr;
	assign tag_ar_valid_o = req_valid;
	assign fifo_wren_o    = wren;
	assign fifo_wdata_o   = wdata;

endmodule

`default_nettype wire

//--- tag_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module tag_fifo import dram_cache_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              wren_i,
	input  wire fifo_entry_t wdata_i,
	input  wire              rden_i,
	output fifo_entry_t      rdata_o,
	output logic             empty_o,
	output logic             afull_o
);

	fifo_entry_t mem [FIFO_DEPTH];
	fifo_ptr_t   wr_ptr, rd_ptr;
	fifo_cnt_t   count;
	logic        push, pop;

	assign push = wren_i && (count != fifo_cnt_t'(FIFO_DEPTH));	// drop on overflow.
	assign pop  = rden_i && !empty_o;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;	// depth is a power of two.
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= wdata_i;
	end

	assign rdata_o = mem[rd_ptr];	// head shown without a read strobe.
	assign empty_o = (count == '0);

	// raised one entry early, so a push already in flight still fits.
	assign afull_o = (count >= fifo_cnt_t'(FIFO_AFULL));

endmodule

`default_nettype wire

//--- tag_store.sv
`timescale 1ns/10ps
`default_nettype none

module tag_store import dram_cache_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,

	input  wire addr_t  ar_addr_i,
	input  wire         ar_valid_i,
	output logic        ar_ready_o,

	output logic        r_valid_o,
	output tag_t        r_tag_o,
	output logic        r_hitv_o,

	input  wire         fill_en_i,
	input  wire index_t fill_index_i,
	input  wire tag_t   fill_tag_i
);

	tag_t                tag_mem [NUM_SETS];
	logic [NUM_SETS-1:0] valid;
	logic                r_valid_q;
	tag_t                r_tag_q;
	logic                r_hitv_q;
	index_t              rd_index;
	logic                rd_fire;

	assign rd_index   = addr_index(ar_addr_i);
	assign ar_ready_o = !r_valid_q;	// one return outstanding at most.
	assign rd_fire    = ar_valid_i && ar_ready_o;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid     <= '0;
			r_valid_q <= 1'b0;
		end else begin
			r_valid_q <= rd_fire;
			if (fill_en_i)
				valid[fill_index_i] <= 1'b1;
		end
	end

	// a fill on the edge of a read is seen from the next read on.
	always_ff @(posedge clk) begin
		if (fill_en_i)
			tag_mem[fill_index_i] <= fill_tag_i;
		if (rd_fire) begin
			r_tag_q  <= tag_mem[rd_index];
			r_hitv_q <= valid[rd_index];
		end
	end

	assign r_valid_o = r_valid_q;
	assign r_tag_o   = r_tag_q;
	assign r_hitv_o  = r_hitv_q;

endmodule

`default_nettype wire

//--- tag_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tag_checker import dram_cache_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,

	input  wire              r_valid_i,
	input  wire tag_t        r_tag_i,
	input  wire              r_hitv_i,

	input  wire fifo_entry_t fifo_rdata_i,
	output logic             fifo_rden_o,

	output logic             fill_en_o,
	output index_t           fill_index_o,
	output tag_t             fill_tag_o,

	output logic             res_valid_o,
	output logic             res_hit_o,
	output logic             res_write_o,
	output tid_t             res_tid_o,
	output addr_t            res_addr_o
);

	logic  head_write;
	tid_t  head_tid;
	addr_t head_addr;
	tag_t  head_tag;
	logic  hit;

	// entry layout is {write, tid, addr}.
	assign {head_write, head_tid, head_addr} = fifo_rdata_i;

	assign head_tag = addr_tag(head_addr);
	assign hit      = r_hitv_i && (r_tag_i == head_tag);

	// returns come back in request order, so the head belongs to this return.
	assign fifo_rden_o  = r_valid_i;
	assign fill_en_o    = r_valid_i && !hit;	// a miss claims the set.
	assign fill_index_o = addr_index(head_addr);
	assign fill_tag_o   = head_tag;

	always_ff @(posedge clk) begin
		if (!rst_n)
			res_valid_o <= 1'b0;
		else
			res_valid_o <= r_valid_i;
	end

	always_ff @(posedge clk) begin
		if (r_valid_i) begin
			res_hit_o   <= hit;
			res_write_o <= head_write;
			res_tid_o   <= head_tid;
			res_addr_o  <= head_addr;
		end
	end

endmodule

`default_nettype wire

//--- dram_cache_tag_top.sv
`timescale 1ns/10ps
`default_nettype none

module dram_cache_tag_top import dram_cache_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,

	input  wire addr_t ar_addr_i,
	input  wire        ar_valid_i,
	output logic       ar_ready_o,

	input  wire addr_t aw_addr_i,
	input  wire        aw_valid_i,
	output logic       aw_ready_o,

	output logic       res_valid_o,
	output logic       res_hit_o,
	output logic       res_write_o,
	output tid_t       res_tid_o,
	output addr_t      res_addr_o
);

	addr_t       tag_ar_addr;
	logic        tag_ar_valid, tag_ar_ready;
	logic        tag_r_valid, tag_r_hitv;
	tag_t        tag_r_tag;
	logic        fifo_wren, fifo_rden, fifo_afull;
	logic        fifo_empty;	// observed by the bound checks.
	fifo_entry_t fifo_wdata, fifo_rdata;
	logic        fill_en;
	index_t      fill_index;
	tag_t        fill_tag;

	index_extractor u_extractor (
		.clk, .rst_n,
		.ar_addr_i, .ar_valid_i, .ar_ready_o,
		.aw_addr_i, .aw_valid_i, .aw_ready_o,
		.tag_ar_addr_o(tag_ar_addr), .tag_ar_valid_o(tag_ar_valid),
		.tag_ar_ready_i(tag_ar_ready),
		.fifo_afull_i(fifo_afull), .fifo_wren_o(fifo_wren), .fifo_wdata_o(fifo_wdata)
	);

	tag_fifo u_fifo (
		.clk, .rst_n,
		.wren_i(fifo_wren), .wdata_i(fifo_wdata), .rden_i(fifo_rden),
		.rdata_o(fifo_rdata), .empty_o(fifo_empty), .afull_o(fifo_afull)
	);

	tag_store u_store (
		.clk, .rst_n,
		.ar_addr_i(tag_ar_addr), .ar_valid_i(tag_ar_valid), .ar_ready_o(tag_ar_ready),
		.r_valid_o(tag_r_valid), .r_tag_o(tag_r_tag), .r_hitv_o(tag_r_hitv),
		.fill_en_i(fill_en), .fill_index_i(fill_index), .fill_tag_i(fill_tag)
	);

	tag_checker u_checker (
		.clk, .rst_n,
		.r_valid_i(tag_r_valid), .r_tag_i(tag_r_tag), .r_hitv_i(tag_r_hitv),
		.fifo_rdata_i(fifo_rdata), .fifo_rden_o(fifo_rden),
		.fill_en_o(fill_en), .fill_index_o(fill_index), .fill_tag_o(fill_tag),
		.res_valid_o, .res_hit_o, .res_write_o, .res_tid_o, .res_addr_o
	);

endmodule

`default_nettype wire

//--- dram_cache_tag_assert.sv
`timescale 1ns/10ps
`default_nettype none

module dram_cache_tag_assert (
	input wire clk,
	input wire rst_n,
	input wire ar_valid_i,
	input wire ar_ready_i,
	input wire aw_valid_i,
	input wire aw_ready_i,
	input wire res_valid_i,
	input wire tag_ar_valid_i,
	input wire tag_ar_ready_i,
	input wire fifo_wren_i,
	input wire fifo_rden_i,
	input wire fifo_empty_i,
	input wire fifo_afull_i
);

	int   fail_count = 0;
	logic accept;

	assign accept = (ar_valid_i && ar_ready_i) || (aw_valid_i && aw_ready_i);

	one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		!(ar_ready_i && aw_ready_i))
		else begin $error("both ready outputs high"); fail_count++; end
	ready_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		(!ar_ready_i || ar_valid_i) && (!aw_ready_i || aw_valid_i))
		else begin $error("ready given to an idle channel"); fail_count++; end
	result_latency: assert property (@(posedge clk) disable iff (!rst_n)
		accept |-> ##3 res_valid_i)
		else begin $error("no result three cycles after accept"); fail_count++; end
	result_cause: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid_i |-> $past(accept, 3))
		else begin $error("result without an accept three cycles before"); fail_count++; end
	tag_read_at_once: assert property (@(posedge clk) disable iff (!rst_n)
		tag_ar_valid_i |-> tag_ar_ready_i)
		else begin $error("tag read request not accepted in its first cycle"); fail_count++; end
	pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_rden_i |-> !fifo_empty_i)
		else begin $error("tag FIFO popped while empty"); fail_count++; end
	push_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_wren_i |-> $past(accept && !fifo_afull_i))
		else begin $error("tag FIFO push without a granted request"); fail_count++; end

endmodule

`default_nettype wire

//--- tb_dram_cache_tag.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dram_cache_tag import dram_cache_pkg::*; ();

	localparam int NUM_ALT   = 16;
	localparam int NUM_RAND  = 120;
	localparam int NUM_AFTER = 40;
	localparam int NUM_REQ   = NUM_ALT + NUM_RAND + NUM_AFTER + 6;
	localparam int TIMEOUT   = 4 * NUM_REQ + 200;

	logic  clk = 1'b0, rst_n;
	addr_t ar_addr_i, aw_addr_i;
	logic  ar_valid_i, aw_valid_i, ar_ready_o, aw_ready_o;
	logic  res_valid_o, res_hit_o, res_write_o;
	tid_t  res_tid_o;
	addr_t res_addr_o;

	int     seed, errors, results, cycles;
	logic   rd_taken = 1'b0, wr_taken = 1'b0, last_rd, have_last;
	tid_t   next_tid;
	tag_t   m_tag [NUM_SETS];	// reference tag store.
	logic   m_valid [NUM_SETS];
	logic   exp_write [$];
	logic   exp_hit [$];
	tid_t   exp_tid [$];
	addr_t  exp_addr [$];
	tag_t   tag_pool [4] = '{20'h00012, 20'h00022, 20'hfffff, 20'h5a5a5};
	index_t index_pool [4] = '{6'h0d, 6'h00, 6'h3f, 6'h15};

	dram_cache_tag_top dut_i (.*);

	bind dram_cache_tag_top dram_cache_tag_assert u_assert (
		.clk, .rst_n, .ar_valid_i, .ar_ready_i(ar_ready_o), .aw_valid_i,
		.aw_ready_i(aw_ready_o), .res_valid_i(res_valid_o), .tag_ar_valid_i(tag_ar_valid),
		.tag_ar_ready_i(tag_ar_ready), .fifo_wren_i(fifo_wren), .fifo_rden_i(fifo_rden),
		.fifo_empty_i(fifo_empty), .fifo_afull_i(fifo_afull)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic bit chance(input int pct);
		int unsigned r;
		r = $random(seed);
		return (r % 100) < pct;
	endfunction

	function automatic addr_t pick_addr();
		logic [31:0] r;
		r = $random(seed);
		return {tag_pool[r[1:0]], index_pool[r[3:2]], r[9:4]};
	endfunction

	task automatic report_mismatch(input string name, input addr_t got, input addr_t exp);
		$display("MISMATCH %s: got %h expected %h", name, got, exp);
		errors++;
	endtask

	// same hit rule as the cache, applied in accept order.
	task automatic record_accept(input logic write, input addr_t a);
		index_t ix;
		tag_t   t;
		logic   hit;
		ix  = a[OFFSET_WIDTH +: INDEX_WIDTH];
		t   = a[ADDR_WIDTH-1 -: TAG_WIDTH];
		hit = m_valid[ix] && (m_tag[ix] == t);
		if (!hit) begin
			m_valid[ix] = 1'b1;
			m_tag[ix]   = t;
		end
		exp_write.push_back(write);
		exp_hit.push_back(hit);
		exp_addr.push_back(a);
		exp_tid.push_back(write ? tid_t'(0) : next_tid);
		if (!write)
			next_tid = next_tid + tid_t'(1);
	endtask

	task automatic check_result();
		logic  e_write;
		logic  e_hit;
		tid_t  e_tid;
		addr_t e_addr;
		results++;
		if (exp_addr.size() == 0) begin
			$display("a result came out with no request outstanding");
			errors++;
		end else begin
			e_write = exp_write.pop_front();
			e_hit   = exp_hit.pop_front();
			e_tid   = exp_tid.pop_front();
			e_addr  = exp_addr.pop_front();
			assert (res_write_o == e_write)
				else report_mismatch("res_write_o", addr_t'(res_write_o), addr_t'(e_write));
			assert (res_hit_o == e_hit)
				else report_mismatch("res_hit_o", addr_t'(res_hit_o), addr_t'(e_hit));
			assert (res_tid_o == e_tid)
				else report_mismatch("res_tid_o", addr_t'(res_tid_o), addr_t'(e_tid));
			assert (res_addr_o == e_addr) else report_mismatch("res_addr_o", res_addr_o, e_addr);
		end
	endtask

	// sampled mid-cycle, where the combinational readies have settled.
	always @(negedge clk) begin
		rd_taken = rst_n && ar_valid_i && ar_ready_o;
		wr_taken = rst_n && aw_valid_i && aw_ready_o;
		assert (rst_n || !(ar_ready_o || aw_ready_o || res_valid_o)) else begin
			$display("a ready or result output is active during reset");
			errors++;
		end
		if (rd_taken || wr_taken) begin
			if (ar_valid_i && aw_valid_i && have_last)
				assert (rd_taken != last_rd) else begin
					$display("arbiter granted the same channel twice with both valid");
					errors++;
				end
			last_rd   = rd_taken;
			have_last = 1'b1;
		end
		if (rd_taken)
			record_accept(1'b0, ar_addr_i);
		if (wr_taken)
			record_accept(1'b1, aw_addr_i);
		if (rst_n && res_valid_o)
			check_result();
	end

	task automatic tick();
		@(posedge clk);
		#1;
		if (rd_taken)
			ar_valid_i = 1'b0;
		if (wr_taken)
			aw_valid_i = 1'b0;
	endtask

	task automatic apply_reset();
		rst_n      = 1'b0;
		ar_valid_i = 1'b0;
		aw_valid_i = 1'b0;
		repeat (16) @(posedge clk);
		foreach (m_valid[i])
			m_valid[i] = 1'b0;
		next_tid  = tid_t'(1);
		have_last = 1'b0;
		#1;
		rst_n = 1'b1;
	endtask

	task automatic send(input logic write, input addr_t a);
		if (write) begin
			aw_addr_i  = a;
			aw_valid_i = 1'b1;
		end else begin
			ar_addr_i  = a;
			ar_valid_i = 1'b1;
		end
		do tick(); while (ar_valid_i || aw_valid_i);
	endtask

	task automatic traffic(input int count, input int pct);
		int sent;
		sent = 0;
		while (sent < count || ar_valid_i || aw_valid_i) begin
			tick();
			if (!ar_valid_i && sent < count && chance(pct)) begin
				ar_addr_i  = pick_addr();
				ar_valid_i = 1'b1;
				sent++;
			end
			if (!aw_valid_i && sent < count && chance(pct)) begin
				aw_addr_i  = pick_addr();
				aw_valid_i = 1'b1;
				sent++;
			end
		end
	endtask

	task automatic drain();
		while (exp_addr.size() != 0)
			tick();
	endtask

	initial begin
		seed       = 66042;
		errors     = 0;
		results    = 0;
		ar_addr_i  = '0;
		aw_addr_i  = '0;
		ar_valid_i = 1'b0;
		aw_valid_i = 1'b0;
		apply_reset();
		send(1'b0, 32'h0001_2340);	// miss, then a back-to-back hit.
		send(1'b0, 32'h0001_2344);
		send(1'b1, 32'h0002_2340);	// same set, new tag.
		send(1'b0, 32'h0001_2348);
		send(1'b1, 32'h0001_2340);
		traffic(NUM_ALT, 100);	// both channels held valid.
		traffic(NUM_RAND, 50);
		drain();
		apply_reset();
		send(1'b0, 32'h0001_2340);	// filled before reset, must miss now.
		traffic(NUM_AFTER, 40);
		drain();
		$display("results %0d, testbench errors %0d, assertion failures %0d",
			results, errors, dut_i.u_assert.fail_count);
		if (errors == 0 && dut_i.u_assert.fail_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d results outstanding", cycles, exp_addr.size());
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- dram_cache_tag.f
dram_cache_pkg.sv
index_extractor.sv
tag_fifo.sv
tag_store.sv
tag_checker.sv
dram_cache_tag_top.sv
dram_cache_tag_assert.sv
tb_dram_cache_tag.sv

//--- Makefile
TOP = tb_dram_cache_tag

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps -f dram_cache_tag.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f dram_cache_tag.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
